// File: design/hmul_round.sv
`timescale 1ns/1ps
`include "l2_mult_macros.svh"

module hmul_round import l2_mult_pkg::*; (
	input logic ap_clk,
	input logic sign,
	input exp_sum_t exp_sum,
	input man_prod_t man_prod,
	input logic is_zero,
	input logic is_inf,
	input logic is_nan,
	output fp16_t product
);

	localparam exp_sum_t exp_max = exp_sum_t'((1 << `L2_EXP_W) - 1);
	localparam fp16_t qnan = {1'b0, {`L2_EXP_W{1'b1}}, 1'b1, {(`L2_MAN_W-1){1'b0}}};

	logic norm_hi; // Product in [2,4)
	logic [`L2_MAN_W-1:0] frac;
	logic guard, sticky;
	logic r1_sign, r1_zero, r1_inf, r1_nan, r1_round_up;
	exp_sum_t r1_exp;
	logic [`L2_MAN_W-1:0] r1_frac;
	logic [`L2_MAN_W:0] rnd_man;
	exp_sum_t fin_exp;
	logic overflow, underflow;

	assign norm_hi = man_prod[2*`L2_MAN_W+1];
	assign frac = norm_hi ? man_prod[2*`L2_MAN_W:`L2_MAN_W+1] : man_prod[2*`L2_MAN_W-1:`L2_MAN_W];
	assign guard = norm_hi ? man_prod[`L2_MAN_W] : man_prod[`L2_MAN_W-1];
	assign sticky = norm_hi ? |man_prod[`L2_MAN_W-1:0] : |man_prod[`L2_MAN_W-2:0];

	always_ff @(posedge ap_clk) begin
		r1_sign <= sign;
		r1_zero <= is_zero;
		r1_inf <= is_inf;
		r1_nan <= is_nan | (is_inf & is_zero); // inf * 0 is invalid
		r1_exp <= exp_sum - exp_sum_t'(`L2_EXP_BIAS) + exp_sum_t'(norm_hi);
		r1_frac <= frac;
		r1_round_up <= guard & (sticky | frac[0]); // Nearest even
	end

	// Carry out of the rounding bumps the exponent, fraction wraps to zero
	assign rnd_man = {1'b0, r1_frac} + (`L2_MAN_W+1)'(r1_round_up);
	assign fin_exp = r1_exp + exp_sum_t'(rnd_man[`L2_MAN_W]);
	assign underflow = fin_exp[`L2_EXP_W+1] | (fin_exp == '0); // Negative or zero
	assign overflow = ~fin_exp[`L2_EXP_W+1] & (fin_exp >= exp_max);

	always_ff @(posedge ap_clk) begin
		if (r1_nan)
			product <= qnan;
		else if (r1_inf)
			product <= {r1_sign, {`L2_EXP_W{1'b1}}, {`L2_MAN_W{1'b0}}};
		else if (r1_zero)
			product <= {r1_sign, {(`L2_FP_W-1){1'b0}}};
		else if (overflow)
			product <= {r1_sign, {`L2_EXP_W{1'b1}}, {`L2_MAN_W{1'b0}}};
		else if (underflow)
			product <= {r1_sign, {(`L2_FP_W-1){1'b0}}};
		else
			product <= {r1_sign, fin_exp[`L2_EXP_W-1:0], rnd_man[`L2_MAN_W-1:0]};
	end

endmodule

// File: design/hmul_unpack.sv
`timescale 1ns/1ps
`include "l2_mult_macros.svh"

module hmul_unpack import l2_mult_pkg::*; (
	input logic ap_clk,
	input fp16_t a,
	input fp16_t b,
	output logic sign,
	output exp_sum_t exp_sum,
	output man_prod_t man_prod,
	output logic is_zero,
	output logic is_inf,
	output logic is_nan
);

	logic [`L2_EXP_W-1:0] ea, eb;
	logic [`L2_MAN_W-1:0] ma, mb;
	logic a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;

	// First stage
	logic s1_sign, s1_zero, s1_inf, s1_nan;
	exp_sum_t s1_exp_sum;
	logic [`L2_MAN_W:0] s1_ma, s1_mb; // With hidden bit

	assign ea = a[`L2_FP_W-2:`L2_MAN_W];
	assign eb = b[`L2_FP_W-2:`L2_MAN_W];
	assign ma = a[`L2_MAN_W-1:0];
	assign mb = b[`L2_MAN_W-1:0];

	// Subnormals flush to zero
	assign a_zero = (ea == '0);
	assign b_zero = (eb == '0);
	assign a_inf = (&ea) & (ma == '0);
	assign b_inf = (&eb) & (mb == '0);
	assign a_nan = (&ea) & (ma != '0);
	assign b_nan = (&eb) & (mb != '0);

	always_ff @(posedge ap_clk) begin
		s1_sign <= a[`L2_FP_W-1] ^ b[`L2_FP_W-1];
		s1_exp_sum <= exp_sum_t'(ea) + exp_sum_t'(eb);
		s1_ma <= {1'b1, ma};
		s1_mb <= {1'b1, mb};
		s1_zero <= a_zero | b_zero;
		s1_inf <= a_inf | b_inf;
		s1_nan <= a_nan | b_nan;
	end

	// Second stage, full mantissa multiply
	always_ff @(posedge ap_clk) begin
		sign <= s1_sign;
		exp_sum <= s1_exp_sum;
		man_prod <= man_prod_t'(s1_ma) * man_prod_t'(s1_mb);
		is_zero <= s1_zero;
		is_inf <= s1_inf;
		is_nan <= s1_nan;
	end

endmodule

// File: design/l2_loop_ctrl.sv
`timescale 1ns/1ps
`include "l2_mult_macros.svh"

module l2_loop_ctrl import l2_mult_pkg::*; (
	input logic ap_clk,
	input logic ap_rst,
	input logic ap_start,
	input logic ap_continue,
	output logic ap_idle,
	output logic ap_ready,
	output logic ap_done,
	input logic indices_empty_n,
	input filt_addr_t indices_dout,
	output logic indices_read,
	output logic filter_ce,
	output filt_addr_t filter_address,
	output logic issue_valid,
	output out_idx_t issue_idx,
	input logic pipe_empty
);

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic done_held; // Done kept up until continue
	logic accept;
	logic last_iter;
	out_idx_t cnt; // Output channel o
	filt_addr_t ichan;

	// New call only when idle, FIFO has data and no done pending
	assign accept = (state == st_idle) & ap_start & indices_empty_n & ~done_held;
	assign last_iter = (cnt == out_idx_t'(`L2_NUM_OUT - 1));

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (accept)
					next_state = st_run;
			end
			st_run: begin
				if (last_iter)
					next_state = st_drain;
			end
			st_drain: begin
				if (pipe_empty) // Last product written
					next_state = st_done;
			end
			st_done: next_state = st_idle;
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= st_idle;
			cnt <= '0;
			done_held <= 1'b0;
		end else begin
			state <= next_state;
			if (state == st_run)
				cnt <= last_iter ? '0 : cnt + out_idx_t'(1);
			if (ap_continue)
				done_held <= 1'b0;
			else if (state == st_done)
				done_held <= 1'b1;
		end
	end

	always_ff @(posedge ap_clk) begin
		if (accept)
			ichan <= indices_dout; // Channel index for this call
	end

	// Address is o * stride + channel
	assign filter_address = filt_addr_t'(cnt * `L2_CHAN_STRIDE + ichan);
	assign filter_ce = (state == st_run);
	assign issue_valid = filter_ce; // Tag leaves with the read
	assign issue_idx = cnt;

	assign indices_read = accept;
	assign ap_idle = (state == st_idle) & ~ap_start;
	assign ap_ready = (state == st_done);
	assign ap_done = (state == st_done) | done_held;

endmodule

// File: design/l2_mult_macros.svh
`ifndef L2_MULT_MACROS_SVH
`define L2_MULT_MACROS_SVH

// Half-precision word layout
`define L2_FP_W 16
`define L2_EXP_W 5
`define L2_MAN_W 10
`define L2_EXP_BIAS 15

// Address and index widths
`define L2_ADDR_W 13
`define L2_IDX_W 5

// Loop shape
`define L2_NUM_OUT 32
`define L2_CHAN_STRIDE 256

// Pipeline latencies in cycles
`define L2_FETCH_LAT 1
`define L2_MUL_LAT 4

`endif

// File: design/l2_mult_pkg.sv
`include "l2_mult_macros.svh"

package l2_mult_pkg;

	typedef logic [`L2_FP_W-1:0] fp16_t;
	typedef logic [`L2_ADDR_W-1:0] filt_addr_t; // Filter address or input channel
	typedef logic [`L2_IDX_W-1:0] out_idx_t;

	// Hidden-bit mantissa product, 11 x 11 bits
	typedef logic [2*`L2_MAN_W+1:0] man_prod_t;

	// Exponent sum, two spare bits for sign and overflow
	typedef logic [`L2_EXP_W+1:0] exp_sum_t;

	typedef enum logic [1:0] {
		st_idle,
		st_run, // Issuing iterations
		st_drain, // Waiting for the last writes
		st_done
	} ctrl_state_t;

endpackage

// File: design/l2_multiply.sv
`timescale 1ns/1ps
`include "l2_mult_macros.svh"

module l2_multiply import l2_mult_pkg::*; (
	input logic ap_clk,
	input logic ap_rst,
	input logic ap_start,
	output logic ap_done,
	input logic ap_continue,
	output logic ap_idle,
	output logic ap_ready,
	input fp16_t intermediate_fmaps_read,
	output filt_addr_t filter_address,
	output logic filter_ce,
	input fp16_t filter_q,
	output out_idx_t products_address,
	output logic products_ce,
	output logic products_we,
	output fp16_t products_d,
	input filt_addr_t indices_dout,
	input logic indices_empty_n,
	output logic indices_read
);

	logic issue_valid;
	out_idx_t issue_idx;
	logic pipe_empty;

	// Between the multiplier halves
	logic mul_sign, mul_zero, mul_inf, mul_nan;
	exp_sum_t mul_exp_sum;
	man_prod_t mul_man_prod;
	fp16_t product;

	l2_loop_ctrl ctrl_inst (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.ap_start(ap_start),
		.ap_continue(ap_continue),
		.ap_idle(ap_idle),
		.ap_ready(ap_ready),
		.ap_done(ap_done),
		.indices_empty_n(indices_empty_n),
		.indices_dout(indices_dout),
		.indices_read(indices_read),
		.filter_ce(filter_ce),
		.filter_address(filter_address),
		.issue_valid(issue_valid),
		.issue_idx(issue_idx),
		.pipe_empty(pipe_empty)
	);

	hmul_unpack unpack_inst (
		.ap_clk(ap_clk),
		.a(filter_q), // Filter word arrives one cycle after ce
		.b(intermediate_fmaps_read),
		.sign(mul_sign),
		.exp_sum(mul_exp_sum),
		.man_prod(mul_man_prod),
		.is_zero(mul_zero),
		.is_inf(mul_inf),
		.is_nan(mul_nan)
	);

	hmul_round round_inst (
		.ap_clk(ap_clk),
		.sign(mul_sign),
		.exp_sum(mul_exp_sum),
		.man_prod(mul_man_prod),
		.is_zero(mul_zero),
		.is_inf(mul_inf),
		.is_nan(mul_nan),
		.product(product)
	);

	l2_product_writer writer_inst (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.issue_valid(issue_valid),
		.issue_idx(issue_idx),
		.product(product),
		.products_ce(products_ce),
		.products_we(products_we),
		.products_address(products_address),
		.products_d(products_d),
		.pipe_empty(pipe_empty)
	);

endmodule

// File: design/l2_product_writer.sv
`timescale 1ns/1ps
`include "l2_mult_macros.svh"

module l2_product_writer import l2_mult_pkg::*; (
	input logic ap_clk,
	input logic ap_rst,
	input logic issue_valid,
	input out_idx_t issue_idx,
	input fp16_t product,
	output logic products_ce,
	output logic products_we,
	output out_idx_t products_address,
	output fp16_t products_d,
	output logic pipe_empty
);

	// Fetch plus multiply, tag meets its product at the last slot
	localparam int unsigned depth = `L2_FETCH_LAT + `L2_MUL_LAT;

	logic [depth-1:0] valid_sr;
	out_idx_t tag_sr [depth];

	always_ff @(posedge ap_clk) begin
		if (ap_rst)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[depth-2:0], issue_valid};
	end

	always_ff @(posedge ap_clk) begin
		tag_sr[0] <= issue_idx;
		for (int i = 1; i < depth; i++)
			tag_sr[i] <= tag_sr[i-1];
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			products_ce <= 1'b0;
			products_we <= 1'b0;
		end else begin
			products_ce <= valid_sr[depth-1];
			products_we <= valid_sr[depth-1];
		end
	end

	always_ff @(posedge ap_clk) begin
		if (valid_sr[depth-1]) begin
			products_address <= tag_sr[depth-1];
			products_d <= product;
		end
	end

	// Last slot counts as the pending write
	assign pipe_empty = ~|valid_sr;

endmodule

// File: files.f
+incdir+design
design/l2_mult_pkg.sv
design/l2_loop_ctrl.sv
design/hmul_unpack.sv
design/hmul_round.sv
design/l2_product_writer.sv
design/l2_multiply.sv
sim/l2_multiply_assertions.sv
sim/l2_multiply_tb.sv

// File: sim/l2_multiply_assertions.sv
`timescale 1ns/1ps

module l2_mult_assertions (
	input logic ap_clk,
	input logic ap_rst,
	input logic indices_read,
	input logic indices_empty_n,
	input logic products_ce,
	input logic products_we,
	input logic ap_ready
);

	int n_fail = 0; // Failed assertion count, summed into the final tally

	// FIFO is popped only when it holds data
	read_needs_data: assert property (@(posedge ap_clk) disable iff (ap_rst)
		indices_read |-> indices_empty_n)
	else begin
		n_fail++;
		$error("indices_read while indices_empty_n is low");
	end

	we_needs_ce: assert property (@(posedge ap_clk) disable iff (ap_rst)
		products_we |-> products_ce)
	else begin
		n_fail++;
		$error("products_we without products_ce");
	end

	// Ready is a single pulse
	ready_one_cycle: assert property (@(posedge ap_clk) disable iff (ap_rst)
		ap_ready |=> !ap_ready)
	else begin
		n_fail++;
		$error("ap_ready high for more than one cycle");
	end

endmodule

// File: sim/l2_multiply_patterns.txt
# columns: test index(dec) fmap(hex) o(dec) filter(hex) expected(hex)
# filter word sits at address o*256+index, expected is filter*fmap
0 5 3e00 0 3c00 3e00
0 5 3e00 1 4000 4200
0 5 3e00 2 c400 c600
0 5 3e00 3 3800 3a00
0 5 3e00 4 3e00 4080
0 5 3e00 5 4100 4380
0 5 3e00 6 3555 3800
0 5 3e00 7 3c01 3e02
0 5 3e00 8 3c03 3e04
0 5 3e00 9 3c02 3e03
0 5 3e00 10 3f01 4141
0 5 3e00 11 3f02 4142
0 5 3e00 12 3f03 4142
0 5 3e00 13 3f04 4143
0 5 3e00 14 3bff 3dff
0 5 3e00 15 3fff 41ff
0 5 3e00 16 3ffd 41fe
0 5 3e00 17 7bff 7c00
0 5 3e00 18 fa00 fc00
0 5 3e00 19 7800 7a00
0 5 3e00 20 7955 7c00
0 5 3e00 21 0400 0600
0 5 3e00 22 0001 0000
0 5 3e00 23 8000 8000
0 5 3e00 24 7c00 7c00
0 5 3e00 25 fc00 fc00
0 5 3e00 26 7c01 7e00
0 5 3e00 27 4248 44b6
0 5 3e00 28 b0cd b334
0 5 3e00 29 5140 53e0
0 5 3e00 30 2e66 30cc
0 5 3e00 31 ca3d ccae
1 130 0400 0 3c00 0400
1 130 0400 1 4000 0800
1 130 0400 2 7bff 43ff
1 130 0400 3 bc00 8400
1 130 0400 4 3bff 0000
1 130 0400 5 bbff 8000
1 130 0400 6 0400 0000
1 130 0400 7 3c01 0401
1 130 0400 8 3e00 0600
1 130 0400 9 3800 0000
1 130 0400 10 4555 0d55
1 130 0400 11 c123 8923
1 130 0400 12 5a5a 225a
1 130 0400 13 3fff 07ff
1 130 0400 14 7c00 7c00
1 130 0400 15 fc00 fc00
1 130 0400 16 7e00 7e00
1 130 0400 17 fd55 7e00
1 130 0400 18 0000 0000
1 130 0400 19 8000 8000
1 130 0400 20 03ff 0000
1 130 0400 21 2a00 0000
1 130 0400 22 b400 8000
1 130 0400 23 6400 2c00
1 130 0400 24 e7d0 afd0
1 130 0400 25 4c00 1400
1 130 0400 26 3d9a 059a
1 130 0400 27 c7ff 8fff
1 130 0400 28 7000 3800
1 130 0400 29 3a00 0000
1 130 0400 30 4101 0901
1 130 0400 31 f555 bd55
2 4095 8000 0 3c00 8000
2 4095 8000 1 bc00 0000
2 4095 8000 2 7c00 7e00
2 4095 8000 3 fc00 7e00
2 4095 8000 4 7c01 7e00
2 4095 8000 5 0000 8000
2 4095 8000 6 8000 0000
2 4095 8000 7 7bff 8000
2 4095 8000 8 0001 8000
2 4095 8000 9 4248 8000
2 4095 8000 10 c248 0000
2 4095 8000 11 7fff 7e00
2 4095 8000 12 1234 8000
2 4095 8000 13 9234 0000
2 4095 8000 14 5555 8000
2 4095 8000 15 d555 0000
2 4095 8000 16 0400 8000
2 4095 8000 17 8400 0000
2 4095 8000 18 3800 8000
2 4095 8000 19 6666 8000
2 4095 8000 20 e666 0000
2 4095 8000 21 2001 8000
2 4095 8000 22 3c10 8000
2 4095 8000 23 4e00 8000
2 4095 8000 24 ce00 0000
2 4095 8000 25 7a00 8000
2 4095 8000 26 fa00 0000
2 4095 8000 27 0f0f 8000
2 4095 8000 28 8f0f 0000
2 4095 8000 29 7c00 7e00
2 4095 8000 30 3c00 8000
2 4095 8000 31 4000 8000

// File: sim/l2_multiply_tb.sv
`timescale 1ns/1ps
`include "l2_mult_macros.svh"

module l2_multiply_tb import l2_mult_pkg::*; ();

	localparam int clk_period = 20;
	localparam int n_out = `L2_NUM_OUT;
	localparam int max_tests = 8;
	localparam int done_lat = 39; // Acceptance to ap_done

	logic ap_clk, ap_rst, ap_start, ap_continue, ap_idle, ap_ready, ap_done;
	logic filter_ce, products_ce, products_we, indices_empty_n, indices_read;
	fp16_t intermediate_fmaps_read, filter_q, products_d;
	filt_addr_t filter_address, indices_dout;
	out_idx_t products_address;

	fp16_t filt_mem [int]; // Sparse filter memory
	filt_addr_t test_idx [max_tests];
	fp16_t test_fmap [max_tests];
	fp16_t exp_prod [max_tests][n_out];
	fp16_t got_prod [n_out];
	int wr_count [n_out];
	int num_tests = 0;
	int n_errors = 0;
	int n_checks = 0;
	int cyc = 0;
	int n_idx_reads, n_filt_reads, n_prod_ce, accept_cyc, done_cyc, ready_cyc;
	filt_addr_t cur_idx;

	l2_multiply l2_multiply_inst (.*);

	bind l2_multiply l2_mult_assertions assertions_inst (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.indices_read(indices_read),
		.indices_empty_n(indices_empty_n),
		.products_ce(products_ce),
		.products_we(products_we),
		.ap_ready(ap_ready)
	);

	initial begin
		ap_clk = 1'b0;
		forever #(clk_period / 2) ap_clk = ~ap_clk;
	end

	always @(posedge ap_clk) cyc <= cyc + 1;

	function automatic fp16_t fill_word(input filt_addr_t addr);
		return {addr[2:0], addr} ^ 16'h5A3C; // Unmapped locations
	endfunction

	// Synchronous read with one cycle latency
	always @(posedge ap_clk) begin
		if (filter_ce) begin
			if (filt_mem.exists(int'(filter_address)))
				filter_q <= filt_mem[int'(filter_address)];
			else
				filter_q <= fill_word(filter_address);
		end
	end

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("[ERROR] %0d ns: %s: got %0h, expected %0h",
				$time, what, actual, expected);
		end
	endtask

	task automatic step();
		@(posedge ap_clk);
		#1;
	endtask

	// Outputs sampled mid-cycle where they are settled
	always @(negedge ap_clk) begin
		if (!ap_rst) begin
			if (indices_read) begin
				n_idx_reads++;
				accept_cyc = cyc;
			end
			if (filter_ce) begin
				compare(filter_address, filt_addr_t'(n_filt_reads * `L2_CHAN_STRIDE + cur_idx),
					$sformatf("filter address of iteration %0d", n_filt_reads));
				n_filt_reads++;
			end
			if (products_ce) begin
				n_prod_ce++;
				if (products_we) begin
					got_prod[products_address] = products_d;
					wr_count[products_address]++;
				end
			end
			if (ap_done && done_cyc < 0)
				done_cyc = cyc;
			if (ap_ready && ready_cyc < 0)
				ready_cyc = cyc;
		end
	end

	task automatic load_patterns(output bit loaded);
		int fd, n, tid, idx, o;
		logic [15:0] fmap, filt, expd;
		string line;
		fd = $fopen("sim/l2_multiply_patterns.txt", "r");
		loaded = 1'b0;
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line[0] != "#") begin
					n = $sscanf(line, "%d %d %h %d %h %h", tid, idx, fmap, o, filt, expd);
					if (n == 6 && tid < max_tests && o < n_out) begin
						test_idx[tid] = filt_addr_t'(idx);
						test_fmap[tid] = fmap;
						exp_prod[tid][o] = expd;
						filt_mem[(o * `L2_CHAN_STRIDE + idx) % (1 << `L2_ADDR_W)] = filt;
						if (tid >= num_tests)
							num_tests = tid + 1;
					end
				end
			end
			$fclose(fd);
			loaded = (num_tests > 0);
		end
	endtask

	task automatic run_call(input int t);
		int d_start, d_fifo, errs_before, wait_cnt;
		errs_before = n_errors;
		d_start = $urandom % 4;
		d_fifo = 2 + $urandom % 4;
		cur_idx = test_idx[t];
		n_idx_reads = 0;
		n_filt_reads = 0;
		n_prod_ce = 0;
		done_cyc = -1;
		ready_cyc = -1;
		for (int o = 0; o < n_out; o++) begin
			wr_count[o] = 0;
			got_prod[o] = '0;
		end
		intermediate_fmaps_read = test_fmap[t]; // Held for the whole call
		compare(ap_idle, 1, "ap_idle before the call");
		repeat (d_start) step();
		ap_start = 1'b1;
		repeat (d_fifo) step(); // Start held while the FIFO is empty
		compare(n_idx_reads, 0, "indices_read with an empty FIFO");
		compare(n_filt_reads, 0, "filter_ce with an empty FIFO");
		indices_dout = test_idx[t];
		indices_empty_n = 1'b1;
		wait_cnt = 0;
		while (n_idx_reads == 0 && wait_cnt < 20) begin
			step();
			wait_cnt++;
		end
		indices_empty_n = 1'b0; // Single entry popped
		wait_cnt = 0;
		while (!ap_done && wait_cnt < 100) begin
			step();
			wait_cnt++;
		end
		if (n_idx_reads == 0 || !ap_done) begin
			n_errors++;
			$display("call %0d: the DUT never accepted the call or never raised ap_done", t);
		end
		// Another entry waits behind the held done
		indices_dout = ~test_idx[t];
		indices_empty_n = 1'b1;
		repeat (3) step();
		compare(ap_done, 1, "ap_done held until ap_continue");
		compare(n_idx_reads, 1, "call accepted while done was held");
		indices_empty_n = 1'b0;
		ap_start = 1'b0;
		ap_continue = 1'b1;
		step();
		ap_continue = 1'b0;
		compare(ap_done, 0, "ap_done after ap_continue");
		compare(done_cyc - accept_cyc, done_lat, "cycles from acceptance to ap_done");
		compare(ready_cyc - accept_cyc, done_lat, "cycles from acceptance to ap_ready");
		compare(n_filt_reads, n_out, "filter reads in the call");
		compare(n_prod_ce, n_out, "products_ce cycles in the call");
		for (int o = 0; o < n_out; o++) begin
			compare(wr_count[o], 1, $sformatf("writes to products entry %0d", o));
			compare(got_prod[o], exp_prod[t][o], $sformatf("product of iteration %0d", o));
		end
		$display("call %0d: index %0d, fmap %h: %s", t, test_idx[t], test_fmap[t],
			(n_errors == errs_before) ? "ok" : "FAILED");
	endtask

	initial begin
		bit loaded;
		ap_rst = 1'b1;
		ap_start = 1'b0;
		ap_continue = 1'b0;
		indices_empty_n = 1'b0;
		indices_dout = '0;
		intermediate_fmaps_read = '0;
		filter_q = '0;
		void'($urandom(70398));
		load_patterns(loaded);
		if (!loaded) begin
			$display("pattern file sim/l2_multiply_patterns.txt could not be read");
			$display("=== FAIL ===");
			$finish;
		end else begin
			repeat (16) @(posedge ap_clk);
			#1;
			ap_rst = 1'b0;
			step();
			for (int t = 0; t < num_tests; t++)
				run_call(t);
			n_errors += l2_multiply_inst.assertions_inst.n_fail;
			$display("%0d calls, %0d checks, %0d errors", num_tests, n_checks, n_errors);
			if (n_errors == 0)
				$display("=== PASS ===");
			else
				$display("=== FAIL ===");
			$finish;
		end
	end

	// Budget of 60 cycles per call plus reset
	initial begin
		wait (num_tests > 0);
		#((num_tests * 60 + 16) * clk_period);
		$display("watchdog: the run did not finish within %0d ns",
			(num_tests * 60 + 16) * clk_period);
		$display("=== FAIL ===");
		$finish;
	end

endmodule
